/* Bender.yml */
package:
  name: csr_unit

sources:
  - design/csr_pkg.sv
  - design/csr_access.sv
  - design/csr_excp_ctrl.sv
  - design/csr_mode_regs.sv
  - design/csr_timer.sv
  - design/csr_unit_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_csr_unit.sv

/* design/csr_access.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_access import csr_pkg::*; (
  input  wire                  clk,
  input  wire                  stall_i,
  input  wire [CSR_ADDR_W-1:0] r_addr_i,
  input  wire [1:0]            rdcnt_i,
  input  wire                  we_i,
  input  wire [CSR_ADDR_W-1:0] w_addr_i,
  input  wire [XLEN-1:0]       w_mask_i,
  input  wire [XLEN-1:0]       w_data_i,
  input  wire csr_view_t       view_i,
  input  wire [2*XLEN-1:0]     stable_cnt_i,
  output logic [XLEN-1:0]      r_data_o,
  output csr_wr_t              wr_o
);

  logic [XLEN-1:0] rd_word;

  // counter reads take over the address decode
  always_comb begin
    rd_word = '0;
    case (rdcnt_i)
      RDCNT_ID:    rd_word = view_i.tid;
      RDCNT_VLOW:  rd_word = stable_cnt_i[XLEN-1:0];
      RDCNT_VHIGH: rd_word = stable_cnt_i[2*XLEN-1:XLEN];
      RDCNT_NONE: begin
        case (r_addr_i[CSR_IDX_W-1:0])
          CSR_CRMD:   rd_word = view_i.crmd;
          CSR_PRMD:   rd_word = view_i.prmd;
          CSR_ECTL:   rd_word = view_i.ectl;
          CSR_ESTAT:  rd_word = view_i.estat;
          CSR_ERA:    rd_word = view_i.era;
          CSR_BADV:   rd_word = view_i.badv;
          CSR_EENTRY: rd_word = view_i.eentry;
          CSR_SAVE0:  rd_word = view_i.save[0];
          CSR_SAVE1:  rd_word = view_i.save[1];
          CSR_SAVE2:  rd_word = view_i.save[2];
          CSR_SAVE3:  rd_word = view_i.save[3];
          CSR_TID:    rd_word = view_i.tid;
          CSR_TCFG:   rd_word = view_i.tcfg;
          CSR_TVAL:   rd_word = view_i.tval;
          // ticlr and unmapped numbers read as zero
          default:    rd_word = '0;
        endcase
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      r_data_o <= rd_word;
    end
  end

  // old value is the read issued one cycle before the write
  assign wr_o = '{
    en:   we_i && !stall_i,
    addr: w_addr_i[CSR_IDX_W-1:0],
    data: (r_data_o & ~w_mask_i) | (w_data_i & w_mask_i)
  };

  // a live slot must carry a defined counter select
  assert property (@(posedge clk) !stall_i |-> !$isunknown(rdcnt_i))
    else $error("rdcnt_i unknown in an unstalled cycle");

endmodule

`default_nettype wire

/* design/csr_excp_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_excp_ctrl import csr_pkg::*; (
  input  wire              stall_i,
  input  wire excp_flags_t excp_i,
  input  wire              ertn_i,
  input  wire [XLEN-1:0]   pc_i,
  input  wire [XLEN-1:0]   vaddr_i,
  output trap_t            trap_o
);

  excp_flags_t flags;
  logic [5:0]  ecode;
  logic [8:0]  esubcode;

  // a stalled slot raises nothing
  assign flags = stall_i ? '0 : excp_i;

  always_comb begin
    ecode    = '0;
    esubcode = '0;
    case (1'b1)
      flags.intr: ecode = ECODE_INT;
      flags.adef: ecode = ECODE_ADE;
      flags.adem: begin
        ecode    = ECODE_ADE;
        esubcode = ESUBCODE_ADEM;
      end
      flags.ale:  ecode = ECODE_ALE;
      flags.sys:  ecode = ECODE_SYS;
      flags.brk:  ecode = ECODE_BRK;
      flags.ine:  ecode = ECODE_INE;
      flags.ipe:  ecode = ECODE_IPE;
      default:    ecode = '0;
    endcase
  end

  // fetch faults report the pc, data faults the access address
  assign trap_o = '{
    excp:     |flags,
    ertn:     ertn_i && !stall_i,
    ecode:    ecode,
    esubcode: esubcode,
    era:      pc_i,
    badv:     flags.adef ? pc_i : vaddr_i,
    badv_we:  flags.adef || flags.adem || flags.ale
  };

  // the pipeline never retires ertn from a faulting slot
  always_comb begin
    assert #0 (!(ertn_i === 1'b1 && (|excp_i) === 1'b1))
      else $error("ertn together with exception flags");
  end

endmodule

`default_nettype wire

/* design/csr_mode_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_mode_regs import csr_pkg::*; (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  stall_i,
  input  wire [INT_HW_W-1:0]   int_i,
  input  wire csr_wr_t         wr_i,
  input  wire trap_t           trap_i,
  input  wire                  timer_int_set_i,
  output crmd_t                crmd_o,
  output prmd_t                prmd_o,
  output logic [XLEN-1:0]      ectl_o,
  output estat_t               estat_o,
  output logic [XLEN-1:0]      era_o,
  output logic [XLEN-1:0]      badv_o,
  output logic [XLEN-1:0]      eentry_o,
  output logic [3:0][XLEN-1:0] save_o,
  output logic                 timer_int_clr_o,
  output logic                 m1_int_o
);

  logic [INT_HW_W-1:0] int_q;
  logic                crmd_we;
  logic                prmd_we;
  logic                ectl_we;
  logic                estat_we;
  logic                era_we;
  logic                badv_we;
  logic                eentry_we;
  estat_t              wr_estat;

  assign crmd_we   = wr_i.en && (wr_i.addr == CSR_CRMD);
  assign prmd_we   = wr_i.en && (wr_i.addr == CSR_PRMD);
  assign ectl_we   = wr_i.en && (wr_i.addr == CSR_ECTL);
  assign estat_we  = wr_i.en && (wr_i.addr == CSR_ESTAT);
  assign era_we    = wr_i.en && (wr_i.addr == CSR_ERA);
  assign badv_we   = wr_i.en && (wr_i.addr == CSR_BADV);
  assign eentry_we = wr_i.en && (wr_i.addr == CSR_EENTRY);
  assign wr_estat  = estat_t'(wr_i.data);

  assign timer_int_clr_o = wr_i.en && (wr_i.addr == CSR_TICLR) && wr_i.data[TICLR_CLR_BIT];

  // exception beats ertn, ertn beats a crmd or prmd write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crmd_o  <= '{da: 1'b1, default: '0};
      prmd_o  <= '0;
      ectl_o  <= '0;
      estat_o <= '0;
      int_q   <= '0;
    end else if (!stall_i) begin
      int_q      <= int_i;
      estat_o.hw <= int_q;
      if (trap_i.excp) begin
        crmd_o.plv       <= 2'b0;
        crmd_o.ie        <= 1'b0;
        prmd_o.pplv      <= crmd_o.plv;
        prmd_o.pie       <= crmd_o.ie;
        estat_o.ecode    <= trap_i.ecode;
        estat_o.esubcode <= trap_i.esubcode;
      end else if (trap_i.ertn) begin
        crmd_o.plv <= prmd_o.pplv;
        crmd_o.ie  <= prmd_o.pie;
      end else begin
        if (crmd_we) begin
          crmd_o <= crmd_t'(wr_i.data & CRMD_WMASK);
        end
        if (prmd_we) begin
          prmd_o <= prmd_t'(wr_i.data & PRMD_WMASK);
        end
      end
      if (ectl_we) begin
        ectl_o <= wr_i.data & ECTL_WMASK;
      end
      if (estat_we) begin
        estat_o.sw <= wr_estat.sw;
      end
      // timer already drops its set pulse when ticlr clears
      estat_o[TIMER_INT_BIT] <= timer_int_set_i ||
                                (estat_o[TIMER_INT_BIT] && !timer_int_clr_o);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      era_o    <= '0;
      badv_o   <= '0;
      eentry_o <= '0;
      save_o   <= '0;
    end else if (!stall_i) begin
      if (trap_i.excp) begin
        era_o <= trap_i.era;
      end else if (era_we) begin
        era_o <= wr_i.data;
      end
      if (trap_i.badv_we) begin
        badv_o <= trap_i.badv;
      end else if (badv_we) begin
        badv_o <= wr_i.data;
      end
      // entry stays 64-byte aligned
      if (eentry_we) begin
        eentry_o <= wr_i.data & EENTRY_WMASK;
      end
      for (int i = 0; i < 4; i++) begin
        if (wr_i.en && (wr_i.addr == CSR_SAVE0 + CSR_IDX_W'(i))) begin
          save_o[i] <= wr_i.data;
        end
      end
    end
  end

  assign m1_int_o = crmd_o.ie && (|(ectl_o[INT_VEC_W-1:0] & estat_o[INT_VEC_W-1:0]));

  // exception and ertn come from one retiring slot, never both
  assert property (@(posedge clk) disable iff (!rst_n) !(trap_i.excp && trap_i.ertn))
    else $error("exception and ertn in the same cycle");

endmodule

`default_nettype wire

/* design/csr_pkg.sv */
`default_nettype none

package csr_pkg;

  localparam int XLEN       = 32;
  localparam int CSR_ADDR_W = 14;
  localparam int CSR_IDX_W  = 9;

  // csr numbers, only the low 9 address bits are decoded
  localparam logic [CSR_IDX_W-1:0] CSR_CRMD   = 9'h000;
  localparam logic [CSR_IDX_W-1:0] CSR_PRMD   = 9'h001;
  localparam logic [CSR_IDX_W-1:0] CSR_ECTL   = 9'h004;
  localparam logic [CSR_IDX_W-1:0] CSR_ESTAT  = 9'h005;
  localparam logic [CSR_IDX_W-1:0] CSR_ERA    = 9'h006;
  localparam logic [CSR_IDX_W-1:0] CSR_BADV   = 9'h007;
  localparam logic [CSR_IDX_W-1:0] CSR_EENTRY = 9'h00c;
  localparam logic [CSR_IDX_W-1:0] CSR_SAVE0  = 9'h030;
  localparam logic [CSR_IDX_W-1:0] CSR_SAVE1  = 9'h031;
  localparam logic [CSR_IDX_W-1:0] CSR_SAVE2  = 9'h032;
  localparam logic [CSR_IDX_W-1:0] CSR_SAVE3  = 9'h033;
  localparam logic [CSR_IDX_W-1:0] CSR_TID    = 9'h040;
  localparam logic [CSR_IDX_W-1:0] CSR_TCFG   = 9'h041;
  localparam logic [CSR_IDX_W-1:0] CSR_TVAL   = 9'h042;
  localparam logic [CSR_IDX_W-1:0] CSR_TICLR  = 9'h044;

  // rdcnt selectors
  localparam logic [1:0] RDCNT_NONE  = 2'd0;
  localparam logic [1:0] RDCNT_ID    = 2'd1;
  localparam logic [1:0] RDCNT_VLOW  = 2'd2;
  localparam logic [1:0] RDCNT_VHIGH = 2'd3;

  localparam logic [5:0] ECODE_INT     = 6'h00;
  localparam logic [5:0] ECODE_ADE     = 6'h08;
  localparam logic [5:0] ECODE_ALE     = 6'h09;
  localparam logic [5:0] ECODE_SYS     = 6'h0b;
  localparam logic [5:0] ECODE_BRK     = 6'h0c;
  localparam logic [5:0] ECODE_INE     = 6'h0d;
  localparam logic [5:0] ECODE_IPE     = 6'h0e;
  localparam logic [8:0] ESUBCODE_ADEM = 9'd1;

  localparam int TVAL_SHIFT    = 2;
  localparam int INT_HW_W      = 8;
  localparam int INT_VEC_W     = 12;
  localparam int TIMER_INT_BIT = 11;
  localparam int TICLR_CLR_BIT = 0;

  // software writable bits
  localparam logic [XLEN-1:0] CRMD_WMASK   = 32'h0000_01ff;
  localparam logic [XLEN-1:0] PRMD_WMASK   = 32'h0000_0007;
  localparam logic [XLEN-1:0] ECTL_WMASK   = 32'h0000_1bff;
  localparam logic [XLEN-1:0] EENTRY_WMASK = 32'hffff_ffc0;

  typedef struct packed {
    logic [22:0] zero;
    logic [1:0]  datm;
    logic [1:0]  datf;
    logic        pg;
    logic        da;
    logic        ie;
    logic [1:0]  plv;
  } crmd_t;

  typedef struct packed {
    logic [28:0] zero;
    logic        pie;
    logic [1:0]  pplv;
  } prmd_t;

  typedef struct packed {
    logic                rsv31;
    logic [8:0]          esubcode;
    logic [5:0]          ecode;
    logic [3:0]          rsv15_12;
    logic                timer;
    logic                rsv10;
    logic [INT_HW_W-1:0] hw;
    logic [1:0]          sw;
  } estat_t;

  typedef struct packed {
    logic [XLEN-TVAL_SHIFT-1:0] initval;
    logic                       periodic;
    logic                       en;
  } tcfg_t;

  typedef struct packed {
    logic intr;
    logic adef;
    logic adem;
    logic ale;
    logic sys;
    logic brk;
    logic ine;
    logic ipe;
  } excp_flags_t;

  // data is already merged under the write mask
  typedef struct packed {
    logic                 en;
    logic [CSR_IDX_W-1:0] addr;
    logic [XLEN-1:0]      data;
  } csr_wr_t;

  typedef struct packed {
    logic            excp;
    logic            ertn;
    logic [5:0]      ecode;
    logic [8:0]      esubcode;
    logic [XLEN-1:0] era;
    logic [XLEN-1:0] badv;
    logic            badv_we;
  } trap_t;

  typedef struct packed {
    crmd_t                 crmd;
    prmd_t                 prmd;
    logic [XLEN-1:0]       ectl;
    estat_t                estat;
    logic [XLEN-1:0]       era;
    logic [XLEN-1:0]       badv;
    logic [XLEN-1:0]       eentry;
    logic [3:0][XLEN-1:0]  save;
    logic [XLEN-1:0]       tid;
    tcfg_t                 tcfg;
    logic [XLEN-1:0]       tval;
  } csr_view_t;

endpackage

`default_nettype wire

/* design/csr_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_timer import csr_pkg::*; (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                stall_i,
  input  wire csr_wr_t       wr_i,
  input  wire                timer_int_clr_i,
  output logic [XLEN-1:0]    tid_o,
  output tcfg_t              tcfg_o,
  output logic [XLEN-1:0]    tval_o,
  output logic               timer_int_set_o,
  output logic [2*XLEN-1:0]  stable_cnt_o
);

  logic            en_q;
  logic            tid_we;
  logic            tcfg_we;
  tcfg_t           wr_tcfg;
  logic [XLEN-1:0] load_val;

  assign tid_we   = wr_i.en && (wr_i.addr == CSR_TID);
  assign tcfg_we  = wr_i.en && (wr_i.addr == CSR_TCFG);
  assign wr_tcfg  = tcfg_t'(wr_i.data);
  assign load_val = XLEN'(tcfg_o.initval) << TVAL_SHIFT;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tid_o  <= '0;
      tcfg_o <= '0;
      tval_o <= '0;
      en_q   <= 1'b0;
    end else if (!stall_i) begin
      if (tid_we) begin
        tid_o <= wr_i.data;
      end
      if (tcfg_we) begin
        tcfg_o <= wr_tcfg;
        tval_o <= XLEN'(wr_tcfg.initval) << TVAL_SHIFT;
        en_q   <= wr_tcfg.en;
      end else if (en_q) begin
        if (tval_o == '0) begin
          // expiry, only periodic mode keeps counting
          tval_o <= tcfg_o.periodic ? load_val : '1;
          en_q   <= tcfg_o.periodic;
        end else begin
          tval_o <= tval_o - 1'b1;
        end
      end
    end
  end

  // a ticlr in the expiry cycle wins over the new interrupt
  assign timer_int_set_o = en_q && (tval_o == '0) && !timer_int_clr_i;

  // free running, ignores stall
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stable_cnt_o <= '0;
    end else begin
      stable_cnt_o <= stable_cnt_o + 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) stall_i |=> $stable(tval_o))
    else $error("tval moved in a stalled cycle");

endmodule

`default_nettype wire

/* design/csr_unit_top.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_unit_top import csr_pkg::*; (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  stall_i,
  input  wire [INT_HW_W-1:0]   int_i,
  input  wire excp_flags_t     excp_i,
  input  wire                  ertn_i,
  input  wire [XLEN-1:0]       pc_i,
  input  wire [XLEN-1:0]       vaddr_i,
  input  wire [CSR_ADDR_W-1:0] csr_r_addr_i,
  input  wire [1:0]            rdcnt_i,
  input  wire                  csr_we_i,
  input  wire [CSR_ADDR_W-1:0] csr_w_addr_i,
  input  wire [XLEN-1:0]       csr_w_mask_i,
  input  wire [XLEN-1:0]       csr_w_data_i,
  output logic [XLEN-1:0]      csr_r_data_o,
  output logic                 m1_int_o
);

  csr_wr_t              wr;
  trap_t                trap;
  csr_view_t            view;
  crmd_t                crmd;
  prmd_t                prmd;
  estat_t               estat;
  tcfg_t                tcfg;
  logic [XLEN-1:0]      ectl;
  logic [XLEN-1:0]      era;
  logic [XLEN-1:0]      badv;
  logic [XLEN-1:0]      eentry;
  logic [3:0][XLEN-1:0] save;
  logic [XLEN-1:0]      tid;
  logic [XLEN-1:0]      tval;
  logic [2*XLEN-1:0]    stable_cnt;
  logic                 timer_int_set;
  logic                 timer_int_clr;

  // register words seen by the read port
  assign view = '{
    crmd:   crmd,
    prmd:   prmd,
    ectl:   ectl,
    estat:  estat,
    era:    era,
    badv:   badv,
    eentry: eentry,
    save:   save,
    tid:    tid,
    tcfg:   tcfg,
    tval:   tval
  };

  csr_access u_access (
    .clk          (clk),
    .stall_i      (stall_i),
    .r_addr_i     (csr_r_addr_i),
    .rdcnt_i      (rdcnt_i),
    .we_i         (csr_we_i),
    .w_addr_i     (csr_w_addr_i),
    .w_mask_i     (csr_w_mask_i),
    .w_data_i     (csr_w_data_i),
    .view_i       (view),
    .stable_cnt_i (stable_cnt),
    .r_data_o     (csr_r_data_o),
    .wr_o         (wr)
  );

  csr_excp_ctrl u_excp_ctrl (
    .stall_i (stall_i),
    .excp_i  (excp_i),
    .ertn_i  (ertn_i),
    .pc_i    (pc_i),
    .vaddr_i (vaddr_i),
    .trap_o  (trap)
  );

  csr_mode_regs u_mode_regs (
    .clk             (clk),
    .rst_n           (rst_n),
    .stall_i         (stall_i),
    .int_i           (int_i),
    .wr_i            (wr),
    .trap_i          (trap),
    .timer_int_set_i (timer_int_set),
    .crmd_o          (crmd),
    .prmd_o          (prmd),
    .ectl_o          (ectl),
    .estat_o         (estat),
    .era_o           (era),
    .badv_o          (badv),
    .eentry_o        (eentry),
    .save_o          (save),
    .timer_int_clr_o (timer_int_clr),
    .m1_int_o        (m1_int_o)
  );

  csr_timer u_timer (
    .clk             (clk),
    .rst_n           (rst_n),
    .stall_i         (stall_i),
    .wr_i            (wr),
    .timer_int_clr_i (timer_int_clr),
    .tid_o           (tid),
    .tcfg_o          (tcfg),
    .tval_o          (tval),
    .timer_int_set_o (timer_int_set),
    .stable_cnt_o    (stable_cnt)
  );

endmodule

`default_nettype wire

/* src.f */
design/csr_pkg.sv
design/csr_access.sv
design/csr_excp_ctrl.sv
design/csr_mode_regs.sv
design/csr_timer.sv
design/csr_unit_top.sv
verif/tb_clock_gen.sv
verif/tb_csr_unit.sv

/* verif/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // reset held low over the first 8 rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

/* verif/tb_csr_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_csr_unit import csr_pkg::*; ();

  // the tests take roughly 600 cycles, so this leaves a wide margin
  localparam int MAX_CYCLES = 4000;

  // writable fields per register
  localparam logic [31:0] CRMD_FIELDS   = 32'h0000_01ff;
  localparam logic [31:0] PRMD_FIELDS   = 32'h0000_0007;
  localparam logic [31:0] ECTL_FIELDS   = 32'h0000_1bff;
  localparam logic [31:0] EENTRY_FIELDS = 32'hffff_ffc0;

  logic        clk;
  logic        rst_n;
  logic        stall;
  logic [7:0]  int_lines;
  excp_flags_t excp;
  logic        ertn;
  logic [31:0] pc;
  logic [31:0] vaddr;
  logic [13:0] r_addr;
  logic [1:0]  rdcnt;
  logic        we;
  logic [13:0] w_addr;
  logic [31:0] w_mask;
  logic [31:0] w_data;
  logic [31:0] r_data;
  logic        m1_int;

  // model state
  logic [31:0] m_crmd;
  logic [31:0] m_prmd;
  logic [31:0] m_ectl;
  logic [31:0] m_estat;
  logic [31:0] m_era;
  logic [31:0] m_badv;
  logic [31:0] m_eentry;
  logic [31:0] m_tid;
  logic [31:0] m_tcfg;
  logic [31:0] m_save [4];
  logic [7:0]  hw_q1;
  logic [7:0]  hw_m;

  int          cyc = 0;
  int          mismatches = 0;
  int          other_errs = 0;
  logic        rd_pending;
  logic [31:0] rd_exp;
  string       rd_name;

  logic [8:0] rw_addr [7] = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3,
                              CSR_ERA, CSR_EENTRY, CSR_ECTL};
  string      rw_name [7] = '{"SAVE0", "SAVE1", "SAVE2", "SAVE3", "ERA", "EENTRY", "ECTL"};

  tb_clock_gen clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  csr_unit_top dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall_i      (stall),
    .int_i        (int_lines),
    .excp_i       (excp),
    .ertn_i       (ertn),
    .pc_i         (pc),
    .vaddr_i      (vaddr),
    .csr_r_addr_i (r_addr),
    .rdcnt_i      (rdcnt),
    .csr_we_i     (we),
    .csr_w_addr_i (w_addr),
    .csr_w_mask_i (w_mask),
    .csr_w_data_i (w_data),
    .csr_r_data_o (r_data),
    .m1_int_o     (m1_int)
  );

  function automatic logic [31:0] expected_word(input logic [8:0] addr);
    case (addr)
      CSR_CRMD:   return m_crmd;
      CSR_PRMD:   return m_prmd;
      CSR_ECTL:   return m_ectl;
      CSR_ESTAT:  return m_estat | {22'd0, hw_m, 2'b00};
      CSR_ERA:    return m_era;
      CSR_BADV:   return m_badv;
      CSR_EENTRY: return m_eentry;
      CSR_SAVE0:  return m_save[0];
      CSR_SAVE1:  return m_save[1];
      CSR_SAVE2:  return m_save[2];
      CSR_SAVE3:  return m_save[3];
      CSR_TID:    return m_tid;
      CSR_TCFG:   return m_tcfg;
      default:    return 32'h0;
    endcase
  endfunction

  function automatic void model_write(input logic [8:0] addr, input logic [31:0] word);
    case (addr)
      CSR_CRMD:   m_crmd = word & CRMD_FIELDS;
      CSR_PRMD:   m_prmd = word & PRMD_FIELDS;
      CSR_ECTL:   m_ectl = word & ECTL_FIELDS;
      CSR_ESTAT:  m_estat[1:0] = word[1:0];
      CSR_ERA:    m_era = word;
      CSR_BADV:   m_badv = word;
      CSR_EENTRY: m_eentry = word & EENTRY_FIELDS;
      CSR_SAVE0:  m_save[0] = word;
      CSR_SAVE1:  m_save[1] = word;
      CSR_SAVE2:  m_save[2] = word;
      CSR_SAVE3:  m_save[3] = word;
      CSR_TID:    m_tid = word;
      CSR_TCFG:   m_tcfg = word;
      CSR_TICLR: begin
        if (word[0]) begin
          m_estat[11] = 1'b0;
        end
      end
      default: ;
    endcase
  endfunction

  // returns {esubcode, ecode}, highest priority first
  function automatic logic [14:0] excp_code(input excp_flags_t f);
    if (f.intr) return {9'd0, ECODE_INT};
    if (f.adef) return {9'd0, ECODE_ADE};
    if (f.adem) return {ESUBCODE_ADEM, ECODE_ADE};
    if (f.ale) return {9'd0, ECODE_ALE};
    if (f.sys) return {9'd0, ECODE_SYS};
    if (f.brk) return {9'd0, ECODE_BRK};
    if (f.ine) return {9'd0, ECODE_INE};
    if (f.ipe) return {9'd0, ECODE_IPE};
    return 15'd0;
  endfunction

  // int_i goes through the sampling flop, then into ESTAT
  always @(posedge clk) begin
    if (!rst_n) begin
      hw_q1 <= '0;
      hw_m  <= '0;
    end else if (!stall) begin
      hw_q1 <= int_lines;
      hw_m  <= hw_q1;
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // compare at the falling edge, away from the driving edge
  always @(negedge clk) begin
    logic [31:0] estat_now;
    logic        m1_exp;
    if (rst_n) begin
      estat_now = expected_word(CSR_ESTAT);
      m1_exp    = m_crmd[2] && (|(m_ectl[11:0] & estat_now[11:0]));
      assert (m1_int === m1_exp) else begin
        mismatches++;
        $display("Mismatch at %0t: m1_int_o expected %b got %b", $time, m1_exp, m1_int);
      end
      if (rd_pending) begin
        assert (r_data === rd_exp) else begin
          mismatches++;
          $display("Mismatch at %0t: csr_r_data_o (%s) expected %h got %h",
                   $time, rd_name, rd_exp, r_data);
        end
        rd_pending = 1'b0;
      end
    end
  end

  task automatic idle_inputs();
    we    <= 1'b0;
    excp  <= '0;
    ertn  <= 1'b0;
    stall <= 1'b0;
  endtask

  task automatic read_check(input logic [8:0] addr, input logic [1:0] sel,
                            input logic [31:0] exp, input string name);
    @(posedge clk);
    r_addr <= {5'd0, addr};
    rdcnt  <= sel;
    @(posedge clk);
    rd_exp     = exp;
    rd_name    = name;
    rd_pending = 1'b1;
  endtask

  task automatic check_reg(input logic [8:0] addr, input string name);
    read_check(addr, RDCNT_NONE, expected_word(addr), name);
  endtask

  task automatic read_word(input logic [8:0] addr, input logic [1:0] sel,
                           output logic [31:0] word);
    @(posedge clk);
    r_addr <= {5'd0, addr};
    rdcnt  <= sel;
    @(posedge clk);
    @(negedge clk);
    word = r_data;
  endtask

  // read in one cycle, masked write in the next
  task automatic write_csr(input logic [8:0] addr, input logic [31:0] mask,
                           input logic [31:0] data, input logic stalled);
    logic [31:0] old;
    old = expected_word(addr);
    @(posedge clk);
    r_addr <= {5'd0, addr};
    rdcnt  <= RDCNT_NONE;
    @(posedge clk);
    we     <= 1'b1;
    w_addr <= {5'd0, addr};
    w_mask <= mask;
    w_data <= data;
    stall  <= stalled;
    @(posedge clk);
    idle_inputs();
    if (!stalled) begin
      model_write(addr, (old & ~mask) | (data & mask));
    end
  endtask

  task automatic raise_excp(input excp_flags_t flags, input logic [31:0] pc_v,
                            input logic [31:0] va, input logic stalled);
    logic [14:0] code;
    code = excp_code(flags);
    @(posedge clk);
    excp  <= flags;
    pc    <= pc_v;
    vaddr <= va;
    stall <= stalled;
    @(posedge clk);
    idle_inputs();
    if (!stalled) begin
      m_prmd[2:0]    = m_crmd[2:0];
      m_crmd[2:0]    = 3'b000;
      m_estat[30:16] = code;
      m_era          = pc_v;
      if (flags.adef) begin
        m_badv = pc_v;
      end else if (flags.adem || flags.ale) begin
        m_badv = va;
      end
    end
  endtask

  // ertn and a CRMD write retire in the same cycle
  task automatic ertn_over_write(input logic [31:0] data);
    @(posedge clk);
    r_addr <= {5'd0, CSR_CRMD};
    rdcnt  <= RDCNT_NONE;
    @(posedge clk);
    we     <= 1'b1;
    w_addr <= {5'd0, CSR_CRMD};
    w_mask <= '1;
    w_data <= data;
    ertn   <= 1'b1;
    @(posedge clk);
    idle_inputs();
    m_crmd[2:0] = m_prmd[2:0];
  endtask

  task automatic run_timer(input int iv, input logic periodic);
    logic [31:0] word;
    logic [31:0] load;
    int          bound;
    int          waited;
    load   = 32'(iv) << 2;
    bound  = 4 * iv + 20;
    waited = 0;
    word   = '0;
    write_csr(CSR_TCFG, '1, load | {30'd0, periodic, 1'b1}, 1'b0);
    while (!word[11] && waited < bound) begin
      read_word(CSR_ESTAT, RDCNT_NONE, word);
      waited += 2;
    end
    assert (word[11]) else begin
      other_errs++;
      $display("timer interrupt did not reach ESTAT within %0d cycles", bound);
    end
    // expiry has set the timer bit by now
    m_estat[11] = 1'b1;
    read_word(CSR_TVAL, RDCNT_NONE, word);
    if (periodic) begin
      assert (word <= load && word + 8 >= load) else begin
        other_errs++;
        $display("TVAL %h is not near the reload value %h after a periodic expiry", word, load);
      end
    end else begin
      assert (word === 32'hffff_ffff) else begin
        mismatches++;
        $display("Mismatch at %0t: csr_r_data_o (TVAL) expected %h got %h",
                 $time, 32'hffff_ffff, word);
      end
    end
    write_csr(CSR_TICLR, 32'h1, 32'h1, 1'b0);
    check_reg(CSR_ESTAT, "ESTAT");
    write_csr(CSR_TCFG, '1, 32'h0, 1'b0);
  endtask

  initial begin
    logic [31:0] word;
    logic [31:0] word2;
    int          k;
    int          t0;
    excp_flags_t flags;
    void'($urandom(66081));
    stall      = 1'b0;
    int_lines  = '0;
    excp       = '0;
    ertn       = 1'b0;
    pc         = '0;
    vaddr      = '0;
    r_addr     = '0;
    rdcnt      = RDCNT_NONE;
    we         = 1'b0;
    w_addr     = '0;
    w_mask     = '0;
    w_data     = '0;
    rd_pending = 1'b0;
    m_crmd     = 32'h0000_0008;
    m_prmd     = '0;
    m_ectl     = '0;
    m_estat    = '0;
    m_era      = '0;
    m_badv     = '0;
    m_eentry   = '0;
    m_tid      = '0;
    m_tcfg     = '0;
    for (int i = 0; i < 4; i++) begin
      m_save[i] = '0;
    end
    wait (rst_n === 1'b1);

    // masked writes, every fifth one stalled
    for (int i = 0; i < 28; i++) begin
      k = i % 7;
      write_csr(rw_addr[k], $urandom, $urandom, (i % 5) == 4);
      check_reg(rw_addr[k], rw_name[k]);
    end

    // exception entry
    for (int i = 0; i < 10; i++) begin
      write_csr(CSR_CRMD, 32'h7, {29'd0, 1'b1, 2'($urandom)}, 1'b0);
      flags = excp_flags_t'(8'($urandom_range(255, 1)));
      raise_excp(flags, $urandom, $urandom, (i % 4) == 3);
      check_reg(CSR_CRMD, "CRMD");
      check_reg(CSR_PRMD, "PRMD");
      check_reg(CSR_ESTAT, "ESTAT");
      check_reg(CSR_ERA, "ERA");
      check_reg(CSR_BADV, "BADV");
    end

    // exception return wins over a CRMD write
    write_csr(CSR_CRMD, 32'h7, 32'h7, 1'b0);
    raise_excp(excp_flags_t'(8'h08), $urandom, $urandom, 1'b0);
    check_reg(CSR_PRMD, "PRMD");
    ertn_over_write($urandom);
    check_reg(CSR_CRMD, "CRMD");

    // timer, one-shot then periodic
    write_csr(CSR_ECTL, '1, 32'h0, 1'b0);
    run_timer(5, 1'b0);
    run_timer(8, 1'b1);

    // interrupt lines against ECTL and crmd.ie
    for (int i = 0; i < 12; i++) begin
      write_csr(CSR_ECTL, '1, $urandom, 1'b0);
      write_csr(CSR_CRMD, 32'h4, $urandom, 1'b0);
      write_csr(CSR_ESTAT, 32'h3, $urandom, 1'b0);
      @(posedge clk);
      int_lines <= 8'($urandom);
      repeat (4) @(posedge clk);
    end
    int_lines <= '0;

    // stable counter and TID through the rdcnt port
    write_csr(CSR_TID, '1, $urandom, 1'b0);
    read_check(9'h0, RDCNT_ID, m_tid, "TID by rdcnt");
    for (int i = 0; i < 4; i++) begin
      read_word(9'h0, RDCNT_VLOW, word);
      t0 = cyc;
      repeat ($urandom_range(12, 1)) @(posedge clk);
      read_word(9'h0, RDCNT_VLOW, word2);
      assert (word2 - word == 32'(cyc - t0)) else begin
        mismatches++;
        $display("Mismatch at %0t: csr_r_data_o (counter delta) expected %0d got %0d",
                 $time, cyc - t0, word2 - word);
      end
    end

    repeat (2) @(posedge clk);
    $display("errors: %0d mismatches, %0d other failures", mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
